//--- hw/mbox_pkg.sv
package mbox_pkg;

    // Mailbox data word and APB byte address
    typedef logic [31:0] mbox_data_t;
    typedef logic [7:0]  mbox_addr_t;

    // Register byte offsets on the APB side
    localparam mbox_addr_t LOCK_OFFSET     = 8'h00;
    localparam mbox_addr_t DLEN_OFFSET     = 8'h04;
    localparam mbox_addr_t DATAIN_OFFSET   = 8'h08;
    localparam mbox_addr_t DATAOUT_OFFSET  = 8'h0C;
    localparam mbox_addr_t EXECUTE_OFFSET  = 8'h10;
    localparam mbox_addr_t CHECKSUM_OFFSET = 8'h14;
    localparam mbox_addr_t STATUS_OFFSET   = 8'h18;

    // Bit positions inside STATUS
    localparam int STATUS_LOCK_BIT = 0;
    localparam int STATUS_EXEC_BIT = 1;

    // Decoded register, encoded as its offset
    typedef enum logic [7:0] {
        REG_LOCK     = 8'h00,
        REG_DLEN     = 8'h04,
        REG_DATAIN   = 8'h08,
        REG_DATAOUT  = 8'h0C,
        REG_EXECUTE  = 8'h10,
        REG_CHECKSUM = 8'h14,
        REG_STATUS   = 8'h18,
        REG_INVALID  = 8'hFF
    } mbox_reg_e;

    // Lock and execute FSM
    typedef enum logic [1:0] {
        MBOX_IDLE    = 2'd0,
        MBOX_LOCKED  = 2'd1,
        MBOX_EXECUTE = 2'd2
    } mbox_state_e;

endpackage

//--- hw/mbox_sram.sv
module mbox_sram #(
    parameter int  MBOX_DEPTH = 16,
    localparam int ADDR_W     = (MBOX_DEPTH > 1) ? $clog2(MBOX_DEPTH) : 1
) (
    input  logic                 core_clk,
    input  logic                 cs,
    input  logic                 we,
    input  logic [ADDR_W-1:0]    addr,
    input  mbox_pkg::mbox_data_t wdata,
    output mbox_pkg::mbox_data_t rdata
);

    mbox_pkg::mbox_data_t mem [MBOX_DEPTH];

    // Single port, write or registered read per cycle
    always_ff @(posedge core_clk) begin
        if (cs) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

//--- hw/mbox_apb_stage.sv
module mbox_apb_stage (
    input  logic                 core_clk,
    input  logic                 reset,

    // APB slave
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  mbox_pkg::mbox_addr_t paddr,
    input  mbox_pkg::mbox_data_t pwdata,
    output mbox_pkg::mbox_data_t prdata,
    output logic                 pready,
    output logic                 pslverr,

    // Request towards the control stage
    output logic                 req_valid,
    output mbox_pkg::mbox_reg_e  req_reg,
    output logic                 req_write,
    output mbox_pkg::mbox_data_t req_wdata,

    // Response from the control stage
    input  logic                 rsp_valid,
    input  mbox_pkg::mbox_data_t rsp_rdata,
    input  logic                 rsp_err
);

    typedef enum logic [1:0] {
        APB_IDLE   = 2'd0,
        APB_ISSUED = 2'd1,
        APB_DONE   = 2'd2
    } apb_state_e;

    apb_state_e          state;
    apb_state_e          state_nxt;
    logic                access;
    logic                issue;
    mbox_pkg::mbox_reg_e reg_dec;

    assign access = psel && penable;

    // Only the first access cycle of a transfer issues a request
    assign issue = (state == APB_IDLE) && access;

    // Byte address to register, exact match only
    always_comb begin
        case (paddr)
            mbox_pkg::LOCK_OFFSET:     reg_dec = mbox_pkg::REG_LOCK;
            mbox_pkg::DLEN_OFFSET:     reg_dec = mbox_pkg::REG_DLEN;
            mbox_pkg::DATAIN_OFFSET:   reg_dec = mbox_pkg::REG_DATAIN;
            mbox_pkg::DATAOUT_OFFSET:  reg_dec = mbox_pkg::REG_DATAOUT;
            mbox_pkg::EXECUTE_OFFSET:  reg_dec = mbox_pkg::REG_EXECUTE;
            mbox_pkg::CHECKSUM_OFFSET: reg_dec = mbox_pkg::REG_CHECKSUM;
            mbox_pkg::STATUS_OFFSET:   reg_dec = mbox_pkg::REG_STATUS;
            default:                   reg_dec = mbox_pkg::REG_INVALID;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            APB_IDLE: begin
                if (access) begin
                    state_nxt = APB_ISSUED;
                end
            end
            APB_ISSUED: begin
                if (rsp_valid) begin
                    state_nxt = APB_DONE;
                end
            end
            APB_DONE: begin
                // Host drops penable once pready has been seen
                if (!penable) begin
                    state_nxt = APB_IDLE;
                end
            end
            default: begin
                state_nxt = APB_IDLE;
            end
        endcase
    end

    always_ff @(posedge core_clk) begin
        if (reset) begin
            state     <= APB_IDLE;
            req_valid <= 1'b0;
        end else begin
            state     <= state_nxt;
            req_valid <= issue;
        end
    end

    // Request payload captured once per transfer
    always_ff @(posedge core_clk) begin
        if (issue) begin
            req_reg   <= reg_dec;
            req_write <= pwrite;
            req_wdata <= pwdata;
        end
    end

    // Response only shows on the bus in the pready cycle
    assign pready  = rsp_valid;
    assign pslverr = rsp_valid && rsp_err;
    assign prdata  = rsp_valid ? rsp_rdata : '0;

endmodule

//--- hw/mbox_ctrl.sv
module mbox_ctrl #(
    parameter int  MBOX_DEPTH = 16,
    localparam int ADDR_W     = (MBOX_DEPTH > 1) ? $clog2(MBOX_DEPTH) : 1
) (
    input  logic                 core_clk,
    input  logic                 reset,

    // Request from the APB stage
    input  logic                 req_valid,
    input  mbox_pkg::mbox_reg_e  req_reg,
    input  logic                 req_write,
    input  mbox_pkg::mbox_data_t req_wdata,

    // Response, one cycle after the request
    output logic                 rsp_valid,
    output mbox_pkg::mbox_data_t rsp_rdata,
    output logic                 rsp_err,

    // Storage port
    output logic                 sram_cs,
    output logic                 sram_we,
    output logic [ADDR_W-1:0]    sram_addr,
    output mbox_pkg::mbox_data_t sram_wdata,
    input  mbox_pkg::mbox_data_t sram_rdata,

    output logic                 mailbox_data_avail,
    output logic                 mailbox_lock
);

    // Count has to reach MBOX_DEPTH itself
    localparam int CNT_W = $clog2(MBOX_DEPTH + 1);

    typedef logic [CNT_W-1:0] cnt_t;

    mbox_pkg::mbox_state_e state;
    mbox_pkg::mbox_state_e state_nxt;
    cnt_t                  count;
    cnt_t                  count_nxt;
    cnt_t                  rd_ptr;
    cnt_t                  rd_ptr_nxt;
    mbox_pkg::mbox_data_t  checksum;
    mbox_pkg::mbox_data_t  checksum_nxt;
    mbox_pkg::mbox_data_t  status;
    mbox_pkg::mbox_data_t  rdata_nxt;
    mbox_pkg::mbox_data_t  rsp_rdata_q;
    logic                  err_nxt;
    logic                  rsp_from_sram;
    logic                  din_ok;
    logic                  dout_ok;

    // Accepted storage accesses
    assign din_ok = req_valid && req_write && (req_reg == mbox_pkg::REG_DATAIN) &&
                    (state == mbox_pkg::MBOX_LOCKED) && (count < cnt_t'(MBOX_DEPTH));
    assign dout_ok = req_valid && !req_write && (req_reg == mbox_pkg::REG_DATAOUT) &&
                     (rd_ptr < count);

    always_comb begin
        status = '0;
        status[mbox_pkg::STATUS_LOCK_BIT] = (state != mbox_pkg::MBOX_IDLE);
        status[mbox_pkg::STATUS_EXEC_BIT] = (state == mbox_pkg::MBOX_EXECUTE);
    end

    always_comb begin
        state_nxt    = state;
        count_nxt    = count;
        rd_ptr_nxt   = rd_ptr;
        checksum_nxt = checksum;
        rdata_nxt    = '0;
        err_nxt      = 1'b0;

        if (req_valid) begin
            case (req_reg)
                mbox_pkg::REG_LOCK: begin
                    if (req_write) begin
                        // Release clears everything
                        state_nxt    = mbox_pkg::MBOX_IDLE;
                        count_nxt    = '0;
                        rd_ptr_nxt   = '0;
                        checksum_nxt = '0;
                    end else if (state == mbox_pkg::MBOX_IDLE) begin
                        state_nxt = mbox_pkg::MBOX_LOCKED;
                    end else begin
                        rdata_nxt = 32'd1;
                    end
                end
                mbox_pkg::REG_DLEN: begin
                    if (req_write) begin
                        err_nxt = 1'b1;
                    end else begin
                        rdata_nxt = mbox_pkg::mbox_data_t'(count);
                    end
                end
                mbox_pkg::REG_DATAIN: begin
                    if (din_ok) begin
                        count_nxt    = count + cnt_t'(1);
                        checksum_nxt = checksum + req_wdata;
                    end else if (req_write) begin
                        // No lock, in execute, or full
                        err_nxt = 1'b1;
                    end
                    // Write-only, reads return zero
                end
                mbox_pkg::REG_DATAOUT: begin
                    if (dout_ok) begin
                        rd_ptr_nxt = rd_ptr + cnt_t'(1);
                    end else begin
                        err_nxt = 1'b1;
                    end
                end
                mbox_pkg::REG_EXECUTE: begin
                    if (!req_write) begin
                        rdata_nxt[0] = status[mbox_pkg::STATUS_EXEC_BIT];
                    end else if (state == mbox_pkg::MBOX_IDLE) begin
                        err_nxt = 1'b1;
                    end else if ((state == mbox_pkg::MBOX_LOCKED) && req_wdata[0]) begin
                        state_nxt = mbox_pkg::MBOX_EXECUTE;
                    end else if ((state == mbox_pkg::MBOX_EXECUTE) && !req_wdata[0]) begin
                        state_nxt = mbox_pkg::MBOX_LOCKED;
                    end
                end
                mbox_pkg::REG_CHECKSUM: begin
                    if (req_write) begin
                        err_nxt = 1'b1;
                    end else begin
                        rdata_nxt = checksum;
                    end
                end
                mbox_pkg::REG_STATUS: begin
                    if (req_write) begin
                        err_nxt = 1'b1;
                    end else begin
                        rdata_nxt = status;
                    end
                end
                default: begin
                    err_nxt = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge core_clk) begin
        if (reset) begin
            state     <= mbox_pkg::MBOX_IDLE;
            count     <= '0;
            rd_ptr    <= '0;
            checksum  <= '0;
            rsp_valid <= 1'b0;
        end else begin
            state     <= state_nxt;
            count     <= count_nxt;
            rd_ptr    <= rd_ptr_nxt;
            checksum  <= checksum_nxt;
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge core_clk) begin
        rsp_rdata_q   <= rdata_nxt;
        rsp_err       <= err_nxt;
        rsp_from_sram <= dout_ok;
    end

    // Storage read data lands in the response cycle
    assign rsp_rdata = rsp_from_sram ? sram_rdata : rsp_rdata_q;

    // Write goes to the count slot, read to the read pointer
    assign sram_cs    = din_ok || dout_ok;
    assign sram_we    = din_ok;
    assign sram_addr  = din_ok ? count[ADDR_W-1:0] : rd_ptr[ADDR_W-1:0];
    assign sram_wdata = req_wdata;

    assign mailbox_lock       = status[mbox_pkg::STATUS_LOCK_BIT];
    assign mailbox_data_avail = status[mbox_pkg::STATUS_EXEC_BIT];

endmodule

//--- hw/mbox_top.sv
module mbox_top #(
    parameter int MBOX_DEPTH = 16
) (
    input  logic                 core_clk,
    input  logic                 reset,

    // APB host port
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  mbox_pkg::mbox_addr_t paddr,
    input  mbox_pkg::mbox_data_t pwdata,
    output mbox_pkg::mbox_data_t prdata,
    output logic                 pready,
    output logic                 pslverr,

    output logic                 mailbox_data_avail,
    output logic                 mailbox_lock
);

    localparam int ADDR_W = (MBOX_DEPTH > 1) ? $clog2(MBOX_DEPTH) : 1;

    // APB stage to control
    logic                 req_valid;
    mbox_pkg::mbox_reg_e  req_reg;
    logic                 req_write;
    mbox_pkg::mbox_data_t req_wdata;
    logic                 rsp_valid;
    mbox_pkg::mbox_data_t rsp_rdata;
    logic                 rsp_err;

    // Control to storage
    logic                 sram_cs;
    logic                 sram_we;
    logic [ADDR_W-1:0]    sram_addr;
    mbox_pkg::mbox_data_t sram_wdata;
    mbox_pkg::mbox_data_t sram_rdata;

    mbox_apb_stage apb_stage_i (
        .core_clk  (core_clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .req_valid (req_valid),
        .req_reg   (req_reg),
        .req_write (req_write),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err)
    );

    mbox_ctrl #(
        .MBOX_DEPTH (MBOX_DEPTH)
    ) ctrl_i (
        .core_clk           (core_clk),
        .reset              (reset),
        .req_valid          (req_valid),
        .req_reg            (req_reg),
        .req_write          (req_write),
        .req_wdata          (req_wdata),
        .rsp_valid          (rsp_valid),
        .rsp_rdata          (rsp_rdata),
        .rsp_err            (rsp_err),
        .sram_cs            (sram_cs),
        .sram_we            (sram_we),
        .sram_addr          (sram_addr),
        .sram_wdata         (sram_wdata),
        .sram_rdata         (sram_rdata),
        .mailbox_data_avail (mailbox_data_avail),
        .mailbox_lock       (mailbox_lock)
    );

    mbox_sram #(
        .MBOX_DEPTH (MBOX_DEPTH)
    ) sram_i (
        .core_clk (core_clk),
        .cs       (sram_cs),
        .we       (sram_we),
        .addr     (sram_addr),
        .wdata    (sram_wdata),
        .rdata    (sram_rdata)
    );

endmodule

//--- sim/mbox_assert.sv
module mbox_assert (
    input logic core_clk,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic mailbox_data_avail,
    input logic mailbox_lock
);
    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions so far
    int assert_failures = 0;

    // pready only inside an access, and never two cycles in a row
    pready_in_access: assert property (@(posedge core_clk) disable iff (reset)
        pready |-> (psel && penable))
        else begin
            $error("pready high outside an APB access");
            assert_failures++;
        end

    pready_one_cycle: assert property (@(posedge core_clk) disable iff (reset)
        pready |=> !pready)
        else begin
            $error("pready high for more than one cycle");
            assert_failures++;
        end

    pslverr_with_pready: assert property (@(posedge core_clk) disable iff (reset)
        pslverr |-> pready)
        else begin
            $error("pslverr high without pready");
            assert_failures++;
        end

    avail_needs_lock: assert property (@(posedge core_clk) disable iff (reset)
        mailbox_data_avail |-> mailbox_lock)
        else begin
            $error("mailbox_data_avail high while unlocked");
            assert_failures++;
        end

    // Two wait states after every setup cycle
    pready_latency: assert property (@(posedge core_clk) disable iff (reset)
        (psel && !penable) |-> ##1 !pready ##1 !pready ##1 pready)
        else begin
            $error("pready not on the third cycle after setup");
            assert_failures++;
        end

endmodule

bind mbox_top mbox_assert assert_i (
    .core_clk           (core_clk),
    .reset              (reset),
    .psel               (psel),
    .penable            (penable),
    .pready             (pready),
    .pslverr            (pslverr),
    .mailbox_data_avail (mailbox_data_avail),
    .mailbox_lock       (mailbox_lock)
);

//--- sim/mbox_tb.sv
module mbox_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MBOX_DEPTH  = 16;
    localparam int FIELDS      = 7;
    localparam int MAX_RECORDS = 64;

    logic                  core_clk;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    mbox_pkg::mbox_addr_t  paddr;
    mbox_pkg::mbox_data_t  pwdata;
    mbox_pkg::mbox_data_t  prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  mailbox_data_avail;
    logic                  mailbox_lock;

    logic [31:0]           testdata [FIELDS*MAX_RECORDS];
    mbox_pkg::mbox_state_e model_state;
    int                    cycle_count = 0;
    int                    cycle_limit = 1000;
    int                    test_errors = 0;
    int                    tests_passed = 0;
    int                    tests_failed = 0;

    mbox_top #(
        .MBOX_DEPTH (MBOX_DEPTH)
    ) dut_i (
        .core_clk           (core_clk),
        .reset              (reset),
        .psel               (psel),
        .penable            (penable),
        .pwrite             (pwrite),
        .paddr              (paddr),
        .pwdata             (pwdata),
        .prdata             (prdata),
        .pready             (pready),
        .pslverr            (pslverr),
        .mailbox_data_avail (mailbox_data_avail),
        .mailbox_lock       (mailbox_lock)
    );

    initial begin
        core_clk = 1'b0;
        forever #20 core_clk = ~core_clk;
    end

    always @(posedge core_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, pready never arrived", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0d ns: %s expected %h, got %h", $time, name,
                     expected, actual);
            test_errors++;
        end
    endtask

    // One APB transfer, response sampled at the pready edge
    task automatic apb_transfer(input logic wr, input mbox_pkg::mbox_addr_t addr,
                                input mbox_pkg::mbox_data_t wdata,
                                output mbox_pkg::mbox_data_t rdata, output logic err);
        @(negedge core_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge core_clk);
        penable = 1'b1;
        @(posedge core_clk);
        while (!pready) begin
            @(posedge core_clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge core_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic logic known_offset(input mbox_pkg::mbox_addr_t addr);
        return (addr == mbox_pkg::LOCK_OFFSET) || (addr == mbox_pkg::DLEN_OFFSET) ||
               (addr == mbox_pkg::DATAIN_OFFSET) || (addr == mbox_pkg::DATAOUT_OFFSET) ||
               (addr == mbox_pkg::EXECUTE_OFFSET) || (addr == mbox_pkg::CHECKSUM_OFFSET) ||
               (addr == mbox_pkg::STATUS_OFFSET);
    endfunction

    // Lock and execute state after an accepted transfer
    function automatic mbox_pkg::mbox_state_e next_model_state(
        input mbox_pkg::mbox_state_e state, input logic wr,
        input mbox_pkg::mbox_addr_t addr, input mbox_pkg::mbox_data_t wdata);
        mbox_pkg::mbox_state_e nxt;
        nxt = state;
        if (addr == mbox_pkg::LOCK_OFFSET) begin
            if (wr) begin
                nxt = mbox_pkg::MBOX_IDLE;
            end else if (state == mbox_pkg::MBOX_IDLE) begin
                nxt = mbox_pkg::MBOX_LOCKED;
            end
        end else if (wr && (addr == mbox_pkg::EXECUTE_OFFSET)) begin
            if ((state == mbox_pkg::MBOX_LOCKED) && wdata[0]) begin
                nxt = mbox_pkg::MBOX_EXECUTE;
            end else if ((state == mbox_pkg::MBOX_EXECUTE) && !wdata[0]) begin
                nxt = mbox_pkg::MBOX_LOCKED;
            end
        end
        return nxt;
    endfunction

    task automatic finish_test(input int test_num);
        if (test_errors == 0) begin
            $display("Test %0d passed", test_num);
            tests_passed++;
        end else begin
            $display("Test %0d failed with %0d errors", test_num, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        int                   rec;
        int                   rep;
        int                   base;
        int                   transfers;
        int                   current_test;
        int                   idle;
        logic                 wr;
        logic                 exp_err;
        logic                 err;
        mbox_pkg::mbox_addr_t addr;
        mbox_pkg::mbox_data_t wdata;
        mbox_pkg::mbox_data_t exp_rdata;
        mbox_pkg::mbox_data_t rdata;

        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        model_state = mbox_pkg::MBOX_IDLE;
        void'($urandom(14));

        for (rec = 0; rec < FIELDS*MAX_RECORDS; rec++) begin
            testdata[rec] = '0;
        end
        $readmemh("sim/mbox_testdata.txt", testdata);

        // Worst case is 8 cycles per transfer
        transfers = 0;
        for (rec = 0; rec < MAX_RECORDS && testdata[rec*FIELDS] != 0; rec++) begin
            transfers += testdata[rec*FIELDS+6];
        end
        cycle_limit = transfers * 8 + 100;
        if (transfers == 0) begin
            $display("No transfers found in sim/mbox_testdata.txt");
        end

        repeat (8) @(posedge core_clk);
        @(negedge core_clk);
        reset = 1'b0;

        current_test = testdata[0];
        for (rec = 0; rec < MAX_RECORDS && testdata[rec*FIELDS] != 0; rec++) begin
            base = rec * FIELDS;
            if (testdata[base] != current_test) begin
                finish_test(current_test);
                current_test = testdata[base];
            end
            wr      = testdata[base+1][0];
            addr    = mbox_pkg::mbox_addr_t'(testdata[base+2]);
            exp_err = testdata[base+5][0];
            if (!known_offset(addr) && !exp_err) begin
                $display("Data file record %0d expects a clean response from address %h",
                         rec, addr);
                test_errors++;
            end
            for (rep = 0; rep < testdata[base+6]; rep++) begin
                wdata     = wr ? testdata[base+3] + rep : testdata[base+3];
                exp_rdata = wr ? testdata[base+4] : testdata[base+4] + rep;
                idle      = $urandom_range(3, 0);
                repeat (idle) @(negedge core_clk);
                apb_transfer(wr, addr, wdata, rdata, err);
                check_value("prdata", exp_rdata, rdata);
                check_value("pslverr", 32'(exp_err), 32'(err));
                if (!exp_err) begin
                    model_state = next_model_state(model_state, wr, addr, wdata);
                end
                check_value("mailbox_lock", 32'(model_state != mbox_pkg::MBOX_IDLE),
                            32'(mailbox_lock));
                check_value("mailbox_data_avail",
                            32'(model_state == mbox_pkg::MBOX_EXECUTE),
                            32'(mailbox_data_avail));
            end
        end
        if (transfers > 0) begin
            finish_test(current_test);
        end

        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d", tests_passed,
                 tests_failed, dut_i.assert_i.assert_failures);
        if (tests_failed == 0 && tests_passed > 0 && dut_i.assert_i.assert_failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- sim/mbox_testdata.txt
// test rw addr wdata exp_rdata exp_err reps, all hex, rw 1 is a write
// A repeated write adds the repeat index to wdata, a repeated read adds it to exp_rdata
1 0 00 00000000 00000000 0 1
1 0 00 00000000 00000001 0 1
1 1 00 00000000 00000000 0 1
1 0 00 00000000 00000000 0 1
1 1 00 00000000 00000000 0 1
2 0 00 00000000 00000000 0 1
2 1 08 11110000 00000000 0 5
2 0 04 00000000 00000005 0 1
2 0 14 00000000 5555000A 0 1
2 0 0C 00000000 11110000 0 5
2 0 0C 00000000 00000000 1 1
3 1 10 00000001 00000000 0 1
3 0 18 00000000 00000003 0 1
3 0 10 00000000 00000001 0 1
3 1 10 00000000 00000000 0 1
3 0 18 00000000 00000001 0 1
3 1 00 00000000 00000000 0 1
3 0 18 00000000 00000000 0 1
4 1 08 12345678 00000000 1 1
4 0 04 00000000 00000000 0 1
4 1 10 00000001 00000000 1 1
4 0 04 00000000 00000000 0 1
4 1 14 0000FFFF 00000000 1 1
4 0 3C 00000000 00000000 1 1
4 1 3C 00000000 00000000 1 1
4 0 04 00000000 00000000 0 1
5 0 00 00000000 00000000 0 1
5 1 08 F0000000 00000000 0 10
5 1 08 DEADBEEF 00000000 1 1
5 0 04 00000000 00000010 0 1
5 0 14 00000000 00000078 0 1
6 1 00 00000000 00000000 0 1
6 0 00 00000000 00000000 0 1
6 0 04 00000000 00000000 0 1
6 0 14 00000000 00000000 0 1
6 0 0C 00000000 00000000 1 1
6 1 00 00000000 00000000 0 1

//--- project.f
hw/mbox_pkg.sv
hw/mbox_sram.sv
hw/mbox_apb_stage.sv
hw/mbox_ctrl.sv
hw/mbox_top.sv
sim/mbox_assert.sv
sim/mbox_tb.sv

//--- Bender.yml
package:
  name: mbox

sources:
  - hw/mbox_pkg.sv
  - hw/mbox_sram.sv
  - hw/mbox_apb_stage.sv
  - hw/mbox_ctrl.sv
  - hw/mbox_top.sv
  - target: simulation
    files:
      - sim/mbox_assert.sv
      - sim/mbox_tb.sv
